// ==== verilog.f ====
design/board_pkg.sv
design/mgmt_pkg.sv
design/pin_sync.sv
design/qsfp_port_ctrl.sv
design/mgmt_cmd_decode.sv
design/status_report.sv
design/board_io_top.sv
bench/board_io_assertions.sv
bench/board_io_tb.sv

// ==== bench/board_io_tb.sv ====
// host and cage model for board_io_top; pin changes are clock aligned, status_ready_i is random with seed 16 apart from one forced stall
`timescale 1ns/10ps

module board_io_tb
    import board_pkg::*, mgmt_pkg::*;
();

    localparam int WAIT_LIMIT = 2000;

    logic                 clk_125mhz_int;
    logic                 reset_i;
    qsfp_pins_t           pins_i;
    mgmt_cmd_u            cmd_i;
    logic                 cmd_valid_i;
    logic                 cmd_ready_o;
    status_rec_t          status_o;
    logic                 status_valid_o;
    logic                 status_ready_i;
    logic [NUM_PORTS-1:0] resetl_o;
    logic [NUM_PORTS-1:0] lpmode_o;
    logic [LED_W-1:0]     led_o;

    int          seed = 16;
    int          cycles;
    logic        stall_status;
    mgmt_cmd_u   led_word;
    // expected cage state, updated from the stimulus
    port_state_t model [NUM_PORTS];
    status_rec_t rec_q [$];

    board_io_top uut (.*);

    initial begin
        clk_125mhz_int = 1'b0;
        forever #4 clk_125mhz_int = ~clk_125mhz_int;
    end

    always @(posedge clk_125mhz_int) begin
        status_ready_i <= stall_status ? 1'b0 : 1'($random(seed));
    end

    // a record is taken on the next edge
    always @(negedge clk_125mhz_int) begin
        if (status_valid_o && status_ready_i) begin
            rec_q.push_back(status_o);
        end
        if (uut.u_assert.error_count != 0) begin
            abort_run("a port assertion on the DUT failed");
        end
    end

    task automatic abort_run(input string reason);
        $display("TEST FAILED");
        $fatal(1, reason);
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("Fail %s expected %0d actual %0d", name, expected, actual);
            abort_run("value mismatch");
        end
    endtask

    task automatic wait_cmd_ready();
        int waited;
        waited = 0;
        @(negedge clk_125mhz_int);
        while (cmd_ready_o !== 1'b1) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                abort_run("cmd_ready_o never went high");
            end
            @(negedge clk_125mhz_int);
        end
    endtask

    // negedges until a status record is offered
    task automatic wait_status_valid();
        int waited;
        waited = 0;
        @(negedge clk_125mhz_int);
        while (status_valid_o !== 1'b1) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                abort_run("status_valid_o never went high");
            end
            @(negedge clk_125mhz_int);
        end
    endtask

    // returns on the edge that moves the command
    task automatic send_cmd(input mgmt_cmd_u cmd);
        @(posedge clk_125mhz_int);
        cmd_i       <= cmd;
        cmd_valid_i <= 1'b1;
        wait_cmd_ready();
        @(posedge clk_125mhz_int);
        cmd_valid_i <= 1'b0;
    endtask

    function automatic mgmt_cmd_u port_cmd(input int port, input cmd_action_t action);
        mgmt_cmd_u cmd;
        cmd                 = '0;
        cmd.port_ctl.kind   = CMD_KIND_PORT;
        cmd.port_ctl.port   = PORT_W'(port);
        cmd.port_ctl.action = action;
        return cmd;
    endfunction

    // edges until resetl_o or lpmode_o of one cage reaches a level
    task automatic cycles_until(input bit watch_lp, input int port, input logic level,
                                output int count);
        logic now;
        count = 0;
        do begin
            @(posedge clk_125mhz_int);
            count++;
            @(negedge clk_125mhz_int);
            now = watch_lp ? lpmode_o[port] : resetl_o[port];
            if (count > WAIT_LIMIT) begin
                abort_run("a cage output never reached the expected level");
            end
        end while (now !== level);
    endtask

    task automatic lpmode_cmd(input int port, input cmd_action_t action, input logic level);
        int count;
        send_cmd(port_cmd(port, action));
        cycles_until(1'b1, port, level, count);
        check("lpmode_o delay", 1, count);
        model[port].lpmode = level;
    endtask

    task automatic expect_record(input int port, input string name);
        status_rec_t rec;
        int          waited;
        waited = 0;
        while (rec_q.size() == 0) begin
            @(posedge clk_125mhz_int);
            waited++;
            if (waited > WAIT_LIMIT) begin
                abort_run({"no status record arrived for ", name});
            end
        end
        rec = rec_q.pop_front();
        check({name, " port"}, port, rec.port);
        check({name, " present"}, model[port].present, rec.present);
        check({name, " int_pending"}, model[port].int_pending, rec.int_pending);
        check({name, " lpmode"}, model[port].lpmode, rec.lpmode);
    endtask

    task automatic expect_none(input int idle);
        repeat (idle) @(posedge clk_125mhz_int);
        check("records beyond the expected ones", 0, rec_q.size());
        @(negedge clk_125mhz_int);
    endtask

    initial begin
        reset_i        = 1'b1;
        pins_i         = '{modprsl: '1, intl: '1};
        cmd_i          = '0;
        cmd_valid_i    = 1'b0;
        status_ready_i = 1'b0;
        stall_status   = 1'b0;
        for (int i = 0; i < NUM_PORTS; i++) begin
            model[i] = '{present: 1'b0, int_pending: 1'b0, in_reset: 1'b1, lpmode: 1'b1};
        end
        repeat (3) @(posedge clk_125mhz_int);
        reset_i <= 1'b0;
        wait_cmd_ready();
        check("reset resetl_o", 0, resetl_o);
        check("reset lpmode_o", 4'hf, lpmode_o);
        check("reset led_o", 0, led_o);
        check("reset status_valid_o", 0, status_valid_o);

        // short present pulse on cage 1
        @(posedge clk_125mhz_int);
        pins_i.modprsl[1] <= 1'b0;
        repeat (DEBOUNCE_CYCLES / 2) @(posedge clk_125mhz_int);
        pins_i.modprsl[1] <= 1'b1;
        expect_none(DEBOUNCE_CYCLES * 3);
        check("glitch resetl_o[1]", 0, resetl_o[1]);

        @(posedge clk_125mhz_int);
        pins_i.modprsl[2] <= 1'b0;
        model[2].present = 1'b1;
        cycles_until(1'b0, 2, 1'b1, cycles);
        check("insertion resetl_o[2] delay",
              SYNC_STAGES + DEBOUNCE_CYCLES + RESET_HOLD_CYCLES, cycles);
        expect_record(2, "insertion");
        expect_none(20);

        led_word             = '0;
        led_word.led_ctl.kind = CMD_KIND_LED;
        led_word.led_ctl.led  = 4'ha;
        send_cmd(led_word);
        @(negedge clk_125mhz_int);
        check("led_o after command", 4'ha, led_o);
        lpmode_cmd(2, CLR_LPMODE, 1'b0);
        lpmode_cmd(2, SET_LPMODE, 1'b1);
        lpmode_cmd(2, CLR_LPMODE, 1'b0);
        send_cmd(port_cmd(2, PULSE_RESET));
        cycles_until(1'b0, 2, 1'b0, cycles);
        check("pulse reset start", 1, cycles);
        cycles_until(1'b0, 2, 1'b1, cycles);
        check("pulse reset length", RESET_HOLD_CYCLES, cycles);

        // interrupt record is held back by the host for a few cycles
        @(posedge clk_125mhz_int);
        stall_status   <= 1'b1;
        pins_i.intl[2] <= 1'b0;
        model[2].int_pending = 1'b1;
        wait_status_valid();
        repeat (4) @(posedge clk_125mhz_int);
        check("records under back-pressure", 0, rec_q.size());
        stall_status <= 1'b0;
        expect_record(2, "interrupt");
        // intl must be released first or the latch sets again
        @(posedge clk_125mhz_int);
        pins_i.intl[2] <= 1'b1;
        repeat (SYNC_STAGES + 1) @(posedge clk_125mhz_int);
        send_cmd(port_cmd(2, CLR_INT));
        model[2].int_pending = 1'b0;
        expect_none(20);

        // removal record shows the cleared interrupt
        @(posedge clk_125mhz_int);
        pins_i.modprsl[2] <= 1'b1;
        model[2].present = 1'b0;
        expect_record(2, "removal");
        @(negedge clk_125mhz_int);
        check("removal resetl_o[2]", 0, resetl_o[2]);
        expect_none(20);

        if (uut.u_assert.error_count != 0) begin
            abort_run("a port assertion on the DUT failed");
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule

// ==== bench/board_io_assertions.sv ====
// port checks for board_io_top; the reset check assumes cmd_ready_o only drops while in reset
`timescale 1ns/10ps

module board_io_assertions
    import board_pkg::*, mgmt_pkg::*;
(
    input logic                 clk_125mhz_int,
    input logic                 reset_i,
    input mgmt_cmd_u            cmd_i,
    input logic                 cmd_valid_i,
    input logic                 cmd_ready_o,
    input status_rec_t          status_o,
    input logic                 status_valid_o,
    input logic                 status_ready_i,
    input logic [NUM_PORTS-1:0] resetl_o,
    input logic [NUM_PORTS-1:0] lpmode_o,
    input logic [LED_W-1:0]     led_o
);

    int error_count = 0;

    // record and valid hold while the host stalls
    status_hold: assert property (@(posedge clk_125mhz_int) disable iff (reset_i)
        status_valid_o && !status_ready_i |=> status_valid_o && $stable(status_o))
    else begin
        $error("status record changed under back-pressure");
        error_count++;
    end

    // outputs sit at their reset values until the decoder is ready
    reset_values: assert property (@(posedge clk_125mhz_int) disable iff (reset_i)
        !cmd_ready_o |-> resetl_o == '0 && lpmode_o == '1 && led_o == '0 && !status_valid_o)
    else begin
        $error("outputs left their reset values before cmd_ready_o rose");
        error_count++;
    end

    // leds only move after an accepted led command
    led_change: assert property (@(posedge clk_125mhz_int) disable iff (reset_i)
        led_o != $past(led_o) |-> $past(cmd_valid_i && cmd_ready_o && cmd_i.led_ctl.kind))
    else begin
        $error("led_o changed without an accepted led command");
        error_count++;
    end

endmodule

bind board_io_top board_io_assertions u_assert (.*);

// ==== design/board_io_top.sv ====
// cage management core at 125 MHz; pins_i may be asynchronous, all host ports are valid/ready in this domain
`timescale 1ns/10ps

module board_io_top
    import board_pkg::*, mgmt_pkg::*;
(
    input  logic                 clk_125mhz_int,
    input  logic                 reset_i,
    input  qsfp_pins_t           pins_i,
    input  mgmt_cmd_u            cmd_i,
    input  logic                 cmd_valid_i,
    output logic                 cmd_ready_o,
    output status_rec_t          status_o,
    output logic                 status_valid_o,
    input  logic                 status_ready_i,
    output logic [NUM_PORTS-1:0] resetl_o,
    output logic [NUM_PORTS-1:0] lpmode_o,
    output logic [LED_W-1:0]     led_o
);

    qsfp_pins_t           pins_sync;
    logic                 rst_int;
    logic [NUM_PORTS-1:0] action_valid;
    cmd_action_t          action;
    port_state_t          port_state [NUM_PORTS];
    logic [NUM_PORTS-1:0] port_event;

    pin_sync u_pin_sync (
        .clk_125mhz_int (clk_125mhz_int),
        .reset_i        (reset_i),
        .pins_i         (pins_i),
        .pins_o         (pins_sync),
        .reset_o        (rst_int)
    );

    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_port
        qsfp_port_ctrl u_port_ctrl (
            .clk_125mhz_int (clk_125mhz_int),
            .reset_i        (rst_int),
            .modprsl_i      (pins_sync.modprsl[i]),
            .intl_i         (pins_sync.intl[i]),
            .action_valid_i (action_valid[i]),
            .action_i       (action),
            .state_o        (port_state[i]),
            .event_o        (port_event[i]),
            .resetl_o       (resetl_o[i])
        );

        assign lpmode_o[i] = port_state[i].lpmode;
    end

    mgmt_cmd_decode u_cmd_decode (
        .clk_125mhz_int (clk_125mhz_int),
        .reset_i        (rst_int),
        .cmd_i          (cmd_i),
        .cmd_valid_i    (cmd_valid_i),
        .cmd_ready_o    (cmd_ready_o),
        .action_valid_o (action_valid),
        .action_o       (action),
        .led_o          (led_o)
    );

    status_report u_status_report (
        .clk_125mhz_int (clk_125mhz_int),
        .reset_i        (rst_int),
        .event_i        (port_event),
        .state_i        (port_state),
        .status_o       (status_o),
        .status_valid_o (status_valid_o),
        .status_ready_i (status_ready_i)
    );

endmodule

// ==== design/status_report.sv ====
// lowest cage first with no fairness; events from one cage merge until its record is loaded
`timescale 1ns/10ps

module status_report
    import board_pkg::*, mgmt_pkg::*;
(
    input  logic                 clk_125mhz_int,
    input  logic                 reset_i,
    input  logic [NUM_PORTS-1:0] event_i,
    input  port_state_t          state_i [NUM_PORTS],
    output status_rec_t          status_o,
    output logic                 status_valid_o,
    input  logic                 status_ready_i
);

    logic [NUM_PORTS-1:0] pending_q;
    logic [NUM_PORTS-1:0] grant_mask;
    logic [PORT_W-1:0]    grant_idx;
    logic                 grant_hit;
    logic                 out_free;
    logic                 load;

    // fixed priority, scan downwards so the lowest index wins
    always_comb begin
        grant_idx = '0;
        grant_hit = 1'b0;
        for (int i = NUM_PORTS - 1; i >= 0; i--) begin
            if (pending_q[i]) begin
                grant_idx = PORT_W'(i);
                grant_hit = 1'b1;
            end
        end
    end

    // output register empties or drains this cycle
    assign out_free = !status_valid_o || status_ready_i;
    assign load     = out_free && grant_hit;

    always_comb begin
        grant_mask = '0;
        if (load) begin
            grant_mask[grant_idx] = 1'b1;
        end
    end

    // an event on the granted cage is already in state_i, so it merges
    always_ff @(posedge clk_125mhz_int) begin
        if (reset_i) begin
            pending_q <= '0;
        end else begin
            pending_q <= (pending_q | event_i) & ~grant_mask;
        end
    end

    always_ff @(posedge clk_125mhz_int) begin
        if (reset_i) begin
            status_valid_o <= 1'b0;
        end else if (out_free) begin
            status_valid_o <= grant_hit;
        end
    end

    // record snapshots the cage state at load time
    always_ff @(posedge clk_125mhz_int) begin
        if (load) begin
            status_o <= '{
                port:        grant_idx,
                present:     state_i[grant_idx].present,
                int_pending: state_i[grant_idx].int_pending,
                lpmode:      state_i[grant_idx].lpmode
            };
        end
    end

endmodule

// ==== design/mgmt_cmd_decode.sv ====
// one command per cycle; ready rises the cycle after internal reset clears, cage actions are one-cycle strobes
`timescale 1ns/10ps

module mgmt_cmd_decode
    import board_pkg::*, mgmt_pkg::*;
(
    input  logic                 clk_125mhz_int,
    input  logic                 reset_i,
    input  mgmt_cmd_u            cmd_i,
    input  logic                 cmd_valid_i,
    output logic                 cmd_ready_o,
    output logic [NUM_PORTS-1:0] action_valid_o,
    output cmd_action_t          action_o,
    output logic [LED_W-1:0]     led_o
);

    logic ready_q;
    logic cmd_accept;

    always_ff @(posedge clk_125mhz_int) begin
        if (reset_i) begin
            ready_q <= 1'b0;
        end else begin
            ready_q <= 1'b1;
        end
    end

    assign cmd_ready_o = ready_q;
    assign cmd_accept  = cmd_valid_i && ready_q;

    // kind bit picks the view of the word
    always_ff @(posedge clk_125mhz_int) begin
        if (reset_i) begin
            action_valid_o <= '0;
            led_o          <= '0;
        end else begin
            action_valid_o <= '0;
            if (cmd_accept) begin
                case (cmd_i.port_ctl.kind)
                    CMD_KIND_PORT: action_valid_o[cmd_i.port_ctl.port] <= 1'b1;
                    CMD_KIND_LED:  led_o <= cmd_i.led_ctl.led;
                endcase
            end
        end
    end

    // action code only matters alongside a strobe
    always_ff @(posedge clk_125mhz_int) begin
        if (cmd_accept) begin
            action_o <= cmd_i.port_ctl.action;
        end
    end

endmodule

// ==== design/qsfp_port_ctrl.sv ====
// one cage; pins must already be synchronized, interrupts are level sensitive and reassert after CLR_INT
`timescale 1ns/10ps

module qsfp_port_ctrl
    import board_pkg::*, mgmt_pkg::*;
(
    input  logic        clk_125mhz_int,
    input  logic        reset_i,
    input  logic        modprsl_i,
    input  logic        intl_i,
    input  logic        action_valid_i,
    input  cmd_action_t action_i,
    output port_state_t state_o,
    output logic        event_o,
    output logic        resetl_o
);

    localparam logic [DEB_CNT_W-1:0]  DEB_LAST  = DEB_CNT_W'(DEBOUNCE_CYCLES - 1);
    localparam logic [HOLD_CNT_W-1:0] HOLD_LAST = HOLD_CNT_W'(RESET_HOLD_CYCLES - 1);

    logic                  present_raw;
    logic                  present_q;
    logic [DEB_CNT_W-1:0]  deb_cnt_q;
    logic                  present_take;

    logic                  resetl_q;
    logic [HOLD_CNT_W-1:0] hold_cnt_q;

    logic                  int_pending_q;
    logic                  int_rise;
    logic                  lpmode_q;
    logic                  event_q;

    // decoded host actions
    logic                  do_set_lp;
    logic                  do_clr_lp;
    logic                  do_pulse_rst;
    logic                  do_clr_int;

    assign do_set_lp    = action_valid_i && (action_i == SET_LPMODE);
    assign do_clr_lp    = action_valid_i && (action_i == CLR_LPMODE);
    assign do_pulse_rst = action_valid_i && (action_i == PULSE_RESET);
    assign do_clr_int   = action_valid_i && (action_i == CLR_INT);

    assign present_raw  = ~modprsl_i;

    // pin has held its new level for DEBOUNCE_CYCLES samples
    assign present_take = (present_raw != present_q) && (deb_cnt_q == DEB_LAST);

    // command clear wins over a still-low intl for one cycle
    assign int_rise = !do_clr_int && !intl_i && present_q && !int_pending_q;

    // presence debouncer, any bounce restarts the count
    always_ff @(posedge clk_125mhz_int) begin
        if (reset_i) begin
            present_q <= 1'b0;
            deb_cnt_q <= '0;
        end else if (present_raw == present_q) begin
            deb_cnt_q <= '0;
        end else if (present_take) begin
            present_q <= present_raw;
            deb_cnt_q <= '0;
        end else begin
            deb_cnt_q <= deb_cnt_q + 1'b1;
        end
    end

    // reset sequencer
    // held low while absent, released RESET_HOLD_CYCLES after insertion
    always_ff @(posedge clk_125mhz_int) begin
        if (reset_i) begin
            resetl_q   <= 1'b0;
            hold_cnt_q <= HOLD_LAST;
        end else if (!present_q || do_pulse_rst) begin
            resetl_q   <= 1'b0;
            hold_cnt_q <= HOLD_LAST;
        end else if (!resetl_q) begin
            if (hold_cnt_q == '0) begin
                resetl_q <= 1'b1;
            end else begin
                hold_cnt_q <= hold_cnt_q - 1'b1;
            end
        end
    end

    // interrupt latch and low-power mode
    always_ff @(posedge clk_125mhz_int) begin
        if (reset_i) begin
            int_pending_q <= 1'b0;
            lpmode_q      <= 1'b1;
        end else begin
            if (do_clr_int) begin
                int_pending_q <= 1'b0;
            end else if (!intl_i && present_q) begin
                int_pending_q <= 1'b1;
            end

            if (do_set_lp) begin
                lpmode_q <= 1'b1;
            end else if (do_clr_lp) begin
                lpmode_q <= 1'b0;
            end
        end
    end

    // strobe lines up with the state it reports
    always_ff @(posedge clk_125mhz_int) begin
        if (reset_i) begin
            event_q <= 1'b0;
        end else begin
            event_q <= present_take || int_rise;
        end
    end

    assign state_o = '{
        present:     present_q,
        int_pending: int_pending_q,
        in_reset:    ~resetl_q,
        lpmode:      lpmode_q
    };

    assign event_o  = event_q;
    assign resetl_o = resetl_q;

endmodule

// ==== design/pin_sync.sv ====
// pins land 2 cycles late; internal reset asserts a cycle after reset_i and releases 2 cycles after it
`timescale 1ns/10ps

module pin_sync
    import board_pkg::*;
(
    input  logic       clk_125mhz_int,
    input  logic       reset_i,
    input  qsfp_pins_t pins_i,
    output qsfp_pins_t pins_o,
    output logic       reset_o
);

    // flop chain for the asynchronous cage pins
    qsfp_pins_t pin_stage_q [SYNC_STAGES];

    // reset stretcher, loads ones while reset_i is high
    logic [SYNC_STAGES-1:0] rst_chain_q;

    // no reset here, the chain flushes within SYNC_STAGES cycles
    always_ff @(posedge clk_125mhz_int) begin
        pin_stage_q[0] <= pins_i;
        for (int i = 1; i < SYNC_STAGES; i++) begin
            pin_stage_q[i] <= pin_stage_q[i-1];
        end
    end

    assign pins_o = pin_stage_q[SYNC_STAGES-1];

    always_ff @(posedge clk_125mhz_int) begin
        if (reset_i) begin
            rst_chain_q <= '1;
        end else begin
            rst_chain_q <= {rst_chain_q[SYNC_STAGES-2:0], 1'b0};
        end
    end

    // released only after the whole chain has drained
    assign reset_o = rst_chain_q[SYNC_STAGES-1];

endmodule

// ==== design/mgmt_pkg.sv ====
// host command and status formats; the 2-bit port field limits the board to four cages
package mgmt_pkg;

    localparam int PORT_W = 2;
    localparam int LED_W  = 4;
    localparam int CMD_W  = 16;

    // kind bit, top of every command word
    localparam logic CMD_KIND_PORT = 1'b0;
    localparam logic CMD_KIND_LED  = 1'b1;

    typedef enum logic [1:0] {
        SET_LPMODE  = 2'd0,
        CLR_LPMODE  = 2'd1,
        PULSE_RESET = 2'd2,
        CLR_INT     = 2'd3
    } cmd_action_t;

    // cage command view
    typedef struct packed {
        logic              kind;
        logic [PORT_W-1:0] port;
        cmd_action_t       action;
        logic [10:0]       pad;
    } port_ctl_t;

    // led command view
    typedef struct packed {
        logic             kind;
        logic [LED_W-1:0] led;
        logic [10:0]      pad;
    } led_ctl_t;

    // one command word, decoded by its kind bit
    typedef union packed {
        port_ctl_t port_ctl;
        led_ctl_t  led_ctl;
    } mgmt_cmd_u;

    // status record sent to the host
    typedef struct packed {
        logic [PORT_W-1:0] port;
        logic              present;
        logic              int_pending;
        logic              lpmode;
    } status_rec_t;

endpackage

// ==== design/board_pkg.sv ====
// board constants for four cages at 125 MHz; cage pins are active low, counter widths assume power-of-two limits
package board_pkg;

    // cage count and synchronizer depth
    localparam int NUM_PORTS   = 4;
    localparam int SYNC_STAGES = 2;

    // cycles a present pin must hold before it is taken
    localparam int DEBOUNCE_CYCLES = 16;
    // cycles resetl stays low after insertion or a reset command
    localparam int RESET_HOLD_CYCLES = 32;

    localparam int DEB_CNT_W  = $clog2(DEBOUNCE_CYCLES);
    localparam int HOLD_CNT_W = $clog2(RESET_HOLD_CYCLES);

    // raw cage pins, active low as on the connector
    typedef struct packed {
        logic [NUM_PORTS-1:0] modprsl;
        logic [NUM_PORTS-1:0] intl;
    } qsfp_pins_t;

    // per-cage state seen by the host
    typedef struct packed {
        logic present;
        logic int_pending;
        logic in_reset;
        logic lpmode;
    } port_state_t;

endpackage
